// File: rtl/mpu_pkg.sv
////////////////////
// PMA checker shared types, widths and the default region table
////////////////////
package mpu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [29:0] word_addr_t;
  typedef logic [31:0] data_t;

  // Upper bound on the region table size
  localparam int MAX_REGIONS = 16;
  localparam int PMA_NUM_REGIONS_DEFAULT = 4;

  // Integrity FIFO depth, must be a power of two
  localparam int MAX_OUTSTANDING_DEFAULT = 4;

  ////////////////////
  // Structs
  ////////////////////

  typedef struct packed {
    logic main;
    logic bufferable;
    logic cacheable;
    logic integrity;
  } pma_attr_t;

  // Half-open word range, low included and high excluded
  typedef struct packed {
    word_addr_t word_addr_low;
    word_addr_t word_addr_high;
    pma_attr_t  attr;
  } pma_region_t;

  // A store has neither instr nor load set
  typedef struct packed {
    addr_t addr;
    logic  instr;
    logic  misaligned;
    logic  load;
  } core_req_t;

  typedef struct packed {
    addr_t addr;
    logic  bufferable;
    logic  cacheable;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  integrity;
  } core_resp_t;

  // No region hit means I/O with nothing else set
  localparam pma_attr_t PMA_ATTR_UNMATCHED = '0;

  ////////////////////
  // Default table
  ////////////////////

  // Byte ranges: r0 0x0-0x10000, r1 0x8000-0x20000,
  // r2 0x1000_0000-0x1000_1000, r3 0x1000_0800-0x1000_2000
  localparam pma_region_t [PMA_NUM_REGIONS_DEFAULT-1:0] PMA_CFG_DEFAULT = '{
    0: '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_4000,
         attr: '{main: 1'b1, bufferable: 1'b0, cacheable: 1'b1, integrity: 1'b1}},
    1: '{word_addr_low: 30'h0000_2000, word_addr_high: 30'h0000_8000,
         attr: '{main: 1'b1, bufferable: 1'b1, cacheable: 1'b0, integrity: 1'b0}},
    2: '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_0400,
         attr: '{main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, integrity: 1'b0}},
    3: '{word_addr_low: 30'h0400_0200, word_addr_high: 30'h0400_0800,
         attr: '{main: 1'b1, bufferable: 1'b0, cacheable: 1'b0, integrity: 1'b0}}
  };

endpackage

// File: rtl/mpu_req_stage.sv
////////////////////
// Request register in front of the PMA lookup
////////////////////
module mpu_req_stage import mpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // Core side, one strobe per request
  input  logic      req_valid_i,
  input  core_req_t req_i,

  // Towards the lookup
  output logic      req_valid_o,
  output core_req_t req_o
);

  ////////////////////
  // Strobe
  ////////////////////

  // Valid lasts exactly one cycle per accepted request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= req_valid_i;
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  // Held between strobes so the comparators see a stable address
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      req_o <= req_i;
    end
  end

endmodule

// File: rtl/pma_lookup.sv
////////////////////
// PMA region lookup, attribute selection and error rule
// Issues the request to the bus or refuses it one cycle later
////////////////////
module pma_lookup import mpu_pkg::*; #(
  parameter int                                PMA_NUM_REGIONS = PMA_NUM_REGIONS_DEFAULT,
  parameter pma_region_t [PMA_NUM_REGIONS-1:0] PMA_CFG         = PMA_CFG_DEFAULT
) (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      req_valid_i,
  input  core_req_t req_i,

  output logic      bus_req_valid_o,
  output bus_req_t  bus_req_o,
  output logic      issue_integrity_o,
  output logic      err_valid_o,
  output addr_t     err_addr_o
);

  word_addr_t                 word_addr;
  logic [PMA_NUM_REGIONS-1:0] region_hit;
  pma_attr_t                  attr_sel;
  logic                       pma_err;
  logic                       is_store;

  assign word_addr = req_i.addr[31:2];
  assign is_store  = !req_i.instr && !req_i.load;

  ////////////////////
  // Region match
  ////////////////////

  always_comb begin
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      region_hit[i] = (word_addr >= PMA_CFG[i].word_addr_low) &&
                      (word_addr <  PMA_CFG[i].word_addr_high);
    end
  end

  // Walk downwards so the lowest hit index is written last
  always_comb begin
    attr_sel = PMA_ATTR_UNMATCHED;
    for (int i = PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        attr_sel = PMA_CFG[i].attr;
      end
    end
  end

  // Fetches and split accesses must target main memory
  assign pma_err = (req_i.instr || req_i.misaligned) && !attr_sel.main;

  ////////////////////
  // Result register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_req_valid_o <= 1'b0;
      err_valid_o     <= 1'b0;
    end else begin
      bus_req_valid_o <= req_valid_i && !pma_err;
      err_valid_o     <= req_valid_i && pma_err;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      bus_req_o.addr       <= req_i.addr;
      bus_req_o.cacheable  <= attr_sel.cacheable;
      // Only stores may be posted
      bus_req_o.bufferable <= attr_sel.bufferable && is_store;
      issue_integrity_o    <= attr_sel.integrity;
      err_addr_o           <= req_i.addr;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_num_regions: assert property (@(posedge clk) disable iff (!rst_n)
    (PMA_NUM_REGIONS >= 1) && (PMA_NUM_REGIONS <= MAX_REGIONS))
    else $error("PMA region count out of range");

  for (genvar g = 0; g < PMA_NUM_REGIONS; g++) begin : g_cfg_chk
    a_bounds: assert property (@(posedge clk) disable iff (!rst_n)
      PMA_CFG[g].word_addr_low < PMA_CFG[g].word_addr_high)
      else $error("PMA region %0d has an empty range", g);
    a_io_uncached: assert property (@(posedge clk) disable iff (!rst_n)
      !PMA_CFG[g].attr.main |-> !PMA_CFG[g].attr.cacheable)
      else $error("PMA region %0d is I/O and cacheable", g);
  end

  a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(bus_req_valid_o && err_valid_o))
    else $error("Bus request and error strobe high together");

endmodule

// File: rtl/resp_integrity_fifo.sv
////////////////////
// Integrity bit FIFO for outstanding bus transactions
////////////////////
module resp_integrity_fifo import mpu_pkg::*; #(
  parameter int MAX_OUTSTANDING = MAX_OUTSTANDING_DEFAULT
) (
  input  logic       clk,
  input  logic       rst_n,

  // Issue side
  input  logic       push_i,
  input  logic       integrity_i,

  // In-order bus responses
  input  logic       bus_resp_valid_i,
  input  data_t      bus_rdata_i,

  output logic       core_resp_valid_o,
  output core_resp_t core_resp_o
);

  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  logic [MAX_OUTSTANDING-1:0] int_mem;
  ptr_t                       wr_ptr;
  ptr_t                       rd_ptr;
  cnt_t                       count;
  logic                       pop;
  logic                       head_integrity;

  assign pop = bus_resp_valid_i;

  // An empty FIFO hands the bit being pushed straight through
  assign head_integrity = (count == '0) ? integrity_i : int_mem[rd_ptr];

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_i && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      int_mem[wr_ptr] <= integrity_i;
    end
  end

  ////////////////////
  // Core response
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_resp_valid_o <= 1'b0;
    end else begin
      core_resp_valid_o <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      core_resp_o.rdata     <= bus_rdata_i;
      core_resp_o.integrity <= head_integrity;
    end
  end

  // Bus side must respect the outstanding limit
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push_i && !pop |-> count < cnt_t'(MAX_OUTSTANDING))
    else $error("Integrity FIFO push while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (count != '0) || push_i)
    else $error("Bus response with no transaction outstanding");

endmodule

// File: rtl/pma_mpu_top.sv
////////////////////
// PMA checker top, request register, lookup and integrity FIFO
////////////////////
module pma_mpu_top import mpu_pkg::*; #(
  parameter int                                PMA_NUM_REGIONS = PMA_NUM_REGIONS_DEFAULT,
  parameter pma_region_t [PMA_NUM_REGIONS-1:0] PMA_CFG         = PMA_CFG_DEFAULT,
  parameter int                                MAX_OUTSTANDING = MAX_OUTSTANDING_DEFAULT
) (
  input  logic       clk,
  input  logic       rst_n,

  // Core request
  input  logic       req_valid_i,
  input  core_req_t  req_i,

  // Bus side
  output logic       bus_req_valid_o,
  output bus_req_t   bus_req_o,
  input  logic       bus_resp_valid_i,
  input  data_t      bus_rdata_i,

  // Core error and response
  output logic       err_valid_o,
  output addr_t      err_addr_o,
  output logic       core_resp_valid_o,
  output core_resp_t core_resp_o
);

  logic      req_q_valid;
  core_req_t req_q;
  logic      issue_integrity;

  mpu_req_stage u_req_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_valid_o (req_q_valid),
    .req_o       (req_q)
  );

  pma_lookup #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG)
  ) u_lookup (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_valid_i       (req_q_valid),
    .req_i             (req_q),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_o         (bus_req_o),
    .issue_integrity_o (issue_integrity),
    .err_valid_o       (err_valid_o),
    .err_addr_o        (err_addr_o)
  );

  // Every issued bus request takes one FIFO slot
  resp_integrity_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_int_fifo (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_i            (bus_req_valid_o),
    .integrity_i       (issue_integrity),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_rdata_i       (bus_rdata_i),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o)
  );

endmodule

// File: tb/tb_pma_mpu.sv
////////////////////
// Random-stimulus testbench for the PMA checker
// Reference model, in-order bus responder and timeout
////////////////////
module tb_pma_mpu import mpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MODE_DATA  = 0;
  localparam int MODE_FETCH = 1;
  localparam int MODE_MIX   = 2;

  localparam int N_DATA  = 150;
  localparam int N_FETCH = 150;
  localparam int N_MIX   = 200;
  localparam int TOTAL_REQ      = N_DATA + N_FETCH + N_MIX;
  localparam int TIMEOUT_CYCLES = TOTAL_REQ * 12 + 100;

  // Expected result of one request, two cycles after it is driven
  typedef struct packed {
    logic  valid;
    logic  err;
    addr_t addr;
    logic  bufferable;
    logic  cacheable;
    logic  integrity;
  } exp_req_t;

  typedef struct packed {
    logic  valid;
    data_t rdata;
    logic  integrity;
  } exp_resp_t;

  logic       clk;
  logic       rst_n;
  logic       req_valid_i;
  core_req_t  req_i;
  logic       bus_req_valid_o;
  bus_req_t   bus_req_o;
  logic       bus_resp_valid_i;
  data_t      bus_rdata_i;
  logic       err_valid_o;
  addr_t      err_addr_o;
  logic       core_resp_valid_o;
  core_resp_t core_resp_o;

  logic [31:0] rng_state = 32'd44443;
  exp_req_t    exp_pipe [2];
  exp_resp_t   exp_resp;
  logic        outq [$];
  int          resp_wait;
  int          check_count;
  int          err_count;
  int          req_total;
  int          cycle_count;

  pma_mpu_top uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_valid_i       (req_valid_i),
    .req_i             (req_i),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_o         (bus_req_o),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_rdata_i       (bus_rdata_i),
    .err_valid_o       (err_valid_o),
    .err_addr_o        (err_addr_o),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Random numbers
  ////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Upper bits only, the low LCG bits repeat quickly
  function automatic int unsigned rand_below(input int unsigned n);
    return (next_rand() >> 16) % n;
  endfunction

  // Inside a region, on its bounds, just past it, or anywhere
  function automatic addr_t pick_addr();
    int unsigned kind;
    int unsigned r;
    word_addr_t  lo;
    word_addr_t  hi;
    word_addr_t  w;
    logic [1:0]  low_bits;
    kind = rand_below(6);
    r    = rand_below(PMA_NUM_REGIONS_DEFAULT);
    lo   = PMA_CFG_DEFAULT[r].word_addr_low;
    hi   = PMA_CFG_DEFAULT[r].word_addr_high;
    case (kind)
      0, 1:    w = lo + word_addr_t'(rand_below(int'(hi - lo)));
      2:       w = lo;
      3:       w = hi - 30'd1;
      4:       w = hi;
      default: w = word_addr_t'(next_rand() >> 2);
    endcase
    low_bits = 2'(rand_below(4));
    return {w, low_bits};
  endfunction

  function automatic core_req_t make_req(input int mode);
    core_req_t   r;
    int unsigned kind;
    r      = '0;
    r.addr = pick_addr();
    if (mode == MODE_DATA) begin
      kind = rand_below(2);
    end else if (mode == MODE_FETCH) begin
      kind = 2 + rand_below(4);
    end else begin
      kind = rand_below(6);
    end
    case (kind)
      0:       r.load = 1'b1;
      1:       r.load = 1'b0;
      2:       r.instr = 1'b1;
      3: begin
        r.misaligned = 1'b1;
        r.load       = 1'b1;
      end
      4:       r.misaligned = 1'b1;
      default: begin
        r.instr      = 1'b1;
        r.misaligned = 1'b1;
      end
    endcase
    return r;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // First region in table order that holds the word wins
  function automatic pma_attr_t model_attr(input addr_t a);
    word_addr_t w;
    w = a[31:2];
    for (int i = 0; i < PMA_NUM_REGIONS_DEFAULT; i++) begin
      if (w >= PMA_CFG_DEFAULT[i].word_addr_low && w < PMA_CFG_DEFAULT[i].word_addr_high) begin
        return PMA_CFG_DEFAULT[i].attr;
      end
    end
    return PMA_ATTR_UNMATCHED;
  endfunction

  function automatic exp_req_t model_req(input core_req_t r);
    pma_attr_t a;
    exp_req_t  e;
    a            = model_attr(r.addr);
    e.valid      = 1'b1;
    e.err        = (r.instr || r.misaligned) && !a.main;
    e.addr       = r.addr;
    e.cacheable  = a.cacheable;
    e.bufferable = a.bufferable && !r.instr && !r.load;
    e.integrity  = a.integrity;
    return e;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    err_count++;
    $display("At %0t ns: %s", $time, msg);
  endtask

  task automatic check_outputs();
    exp_req_t e;
    e = exp_pipe[1];
    if (e.valid && !e.err) begin
      if (!bus_req_valid_o) begin
        note_failure($sformatf("Bus request for address %h never came", e.addr));
      end else begin
        check_value(64'(bus_req_o.addr), 64'(e.addr), "bus address");
        check_value(64'(bus_req_o.cacheable), 64'(e.cacheable), "cacheable");
        check_value(64'(bus_req_o.bufferable), 64'(e.bufferable), "bufferable");
      end
      if (err_valid_o) begin
        note_failure($sformatf("Address %h was refused but should be issued", e.addr));
      end
      outq.push_back(e.integrity);
    end else if (e.valid) begin
      if (!err_valid_o) begin
        note_failure($sformatf("Error strobe for address %h never came", e.addr));
      end else begin
        check_value(64'(err_addr_o), 64'(e.addr), "error address");
      end
      if (bus_req_valid_o) begin
        note_failure($sformatf("Address %h went to the bus but should be refused", e.addr));
      end
    end else begin
      if (bus_req_valid_o) note_failure("Bus request strobe with no request behind it");
      if (err_valid_o) note_failure("Error strobe with no request behind it");
    end
    if (exp_resp.valid) begin
      if (!core_resp_valid_o) begin
        note_failure("Core response missing one cycle after a bus response");
      end else begin
        check_value(64'(core_resp_o.rdata), 64'(exp_resp.rdata), "response data");
        check_value(64'(core_resp_o.integrity), 64'(exp_resp.integrity), "response integrity");
      end
    end else if (core_resp_valid_o) begin
      note_failure("Core response with no bus response before it");
    end
  endtask

  ////////////////////
  // Cycle driver
  ////////////////////

  // Check, answer the bus, then drive the next request, all on the falling edge
  task automatic run_cycle(input logic want_req, input int mode, output logic sent);
    exp_resp_t r_next;
    core_req_t req;
    int        pending;
    @(negedge clk);
    check_outputs();
    r_next           = '0;
    bus_resp_valid_i = 1'b0;
    if (outq.size() > 0) begin
      if (resp_wait == 0) begin
        r_next.valid     = 1'b1;
        r_next.rdata     = next_rand();
        r_next.integrity = outq.pop_front();
        bus_resp_valid_i = 1'b1;
        bus_rdata_i      = r_next.rdata;
        resp_wait        = int'(rand_below(6));
      end else begin
        resp_wait--;
      end
    end
    exp_resp    = r_next;
    exp_pipe[1] = exp_pipe[0];
    exp_pipe[0] = '0;
    // Requests still in the pipeline count against the bus limit
    pending     = outq.size() + ((exp_pipe[1].valid && !exp_pipe[1].err) ? 1 : 0);
    sent        = 1'b0;
    req_valid_i = 1'b0;
    if (want_req && pending < MAX_OUTSTANDING_DEFAULT) begin
      req         = make_req(mode);
      req_i       = req;
      req_valid_i = 1'b1;
      exp_pipe[0] = model_req(req);
      sent        = 1'b1;
      req_total++;
    end
  endtask

  task automatic drain();
    logic sent;
    while (exp_pipe[0].valid || exp_pipe[1].valid || outq.size() > 0 || exp_resp.valid) begin
      run_cycle(1'b0, MODE_DATA, sent);
    end
  endtask

  task automatic run_test(input string name, input int n_req, input int mode, input int gap_pct);
    int   sent_n;
    int   errs_at_start;
    logic sent;
    logic want;
    errs_at_start = err_count;
    sent_n        = 0;
    while (sent_n < n_req) begin
      want = rand_below(100) >= gap_pct;
      run_cycle(want, mode, sent);
      if (sent) sent_n++;
    end
    drain();
    $display("Test %s finished: %0d requests, %0d errors", name, n_req,
             err_count - errs_at_start);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    logic sent;
    clk              = 1'b0;
    rst_n            = 1'b0;
    req_valid_i      = 1'b0;
    req_i            = '0;
    bus_resp_valid_i = 1'b0;
    bus_rdata_i      = '0;
    exp_pipe[0]      = '0;
    exp_pipe[1]      = '0;
    exp_resp         = '0;
    resp_wait        = 0;
    check_count      = 0;
    err_count        = 0;
    req_total        = 0;
    cycle_count      = 0;

    repeat (3) begin
      @(negedge clk);
      if (bus_req_valid_o || err_valid_o || core_resp_valid_o) begin
        note_failure("Output strobe high during reset");
      end
    end
    rst_n = 1'b1;
    // Idle cycles after reset, the model expects every strobe low
    repeat (4) run_cycle(1'b0, MODE_DATA, sent);
    $display("Test reset finished: %0d errors", err_count);

    run_test("data_access", N_DATA, MODE_DATA, 40);
    run_test("fetch_misaligned", N_FETCH, MODE_FETCH, 40);
    run_test("back_to_back", N_MIX, MODE_MIX, 0);

    $display("Requests %0d, checks %0d, errors %0d", req_total, check_count, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
rtl/mpu_pkg.sv
rtl/mpu_req_stage.sv
rtl/pma_lookup.sv
rtl/resp_integrity_fifo.sv
rtl/pma_mpu_top.sv
tb/tb_pma_mpu.sv

// File: Makefile
# Verilator build and run for the PMA checker testbench

VERILATOR ?= verilator
TOP       ?= tb_pma_mpu
SEED_ARGS ?= +verilator+seed+1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
FAIL_MSG  ?= STATUS: FAIL

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --assert -j 0 --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@$(BIN) $(SEED_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
